// ==== Makefile ====
# element unit simulation with Verilator

TOP := elem_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f elem_unit.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== elem_unit.f ====
+incdir+logic
logic/elem_pkg.sv
logic/elem_operand_fifo.sv
logic/elem_sequencer.sv
logic/elem_operand_shift.sv
logic/elem_reducer.sv
logic/elem_unit.sv
tb/elem_properties.sv
tb/elem_tb.sv

// ==== logic/elem_defs.svh ====
//////////////////////////////////////////////////////////////////////
// element unit global sizes
// register word, scalar and operand buffer dimensions
//////////////////////////////////////////////////////////////////////

`ifndef ELEM_DEFS_SVH
`define ELEM_DEFS_SVH

// width of one vector register word in bits
`define ELEM_VREG_W 128

// width of the scalar result returned to the core
`define ELEM_XLEN 32

// operand buffer depth, equal to the credits the source starts with
`define ELEM_OPERAND_CREDITS 2

`endif

// ==== logic/elem_operand_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// operand buffer
// holds incoming register words and hands one credit back per pop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "elem_defs.svh"

module elem_operand_fifo (
    input  wire logic            clk_i,
    input  wire logic            async_rst_ni,
    input  wire logic            operand_valid_i,
    input  wire elem_pkg::vreg_t operand_i,
    input  wire logic            pop_i,
    output logic                 empty_o,
    output elem_pkg::vreg_t      head_o,
    output logic                 operand_credit_o
);

    localparam int unsigned DEPTH = `ELEM_OPERAND_CREDITS;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    elem_pkg::vreg_t  mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] fill_q;
    logic             credit_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    // the source only sends against a credit, so a push always finds room
    assign push = operand_valid_i;
    assign pop  = pop_i & (fill_q != '0);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   fill_q <= fill_q + CNT_W'(1);
                2'b01:   fill_q <= fill_q - CNT_W'(1);
                default: fill_q <= fill_q;
            endcase
            // one credit back per word taken
            credit_q <= pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= operand_i;
        end
    end

    assign empty_o          = (fill_q == '0);
    assign head_o           = mem_q[rd_ptr_q];
    assign operand_credit_o = credit_q;

endmodule

`default_nettype wire

// ==== logic/elem_operand_shift.sv ====
//////////////////////////////////////////////////////////////////////
// operand shifter
// presents one element and one mask bit of the word per beat
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "elem_defs.svh"

module elem_operand_shift (
    input  wire logic                 clk_i,
    input  wire logic                 async_rst_ni,
    input  wire elem_pkg::vreg_t      word_i,
    input  wire logic                 beat_valid_i,
    input  wire elem_pkg::elem_beat_t beat_i,
    output logic                      beat_valid_o,
    output elem_pkg::elem_beat_t      beat_o,
    output elem_pkg::xreg_t           elem_o,
    output logic                      mask_bit_o
);

    elem_pkg::vreg_t      sh_q;
    elem_pkg::vreg_t      shifted;
    elem_pkg::elem_beat_t beat_q;
    logic                 valid_q;

    // mask operations step one bit, the rest one element
    always_comb begin
        if ((beat_i.op == elem_pkg::OP_VPOPC) || (beat_i.op == elem_pkg::OP_VFIRST)) begin
            shifted = sh_q >> 1;
        end else begin
            case (beat_i.sew)
                elem_pkg::SEW_16: shifted = sh_q >> 16;
                elem_pkg::SEW_32: shifted = sh_q >> 32;
                default:          shifted = sh_q >> 8;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= beat_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_valid_i) begin
            beat_q <= beat_i;
            sh_q   <= beat_i.first ? word_i : shifted;
        end
    end

    always_comb begin
        case (beat_q.sew)
            elem_pkg::SEW_16: elem_o = {{(`ELEM_XLEN - 16){1'b0}}, sh_q[15:0]};
            elem_pkg::SEW_32: elem_o = sh_q[`ELEM_XLEN-1:0];
            default:          elem_o = {{(`ELEM_XLEN - 8){1'b0}}, sh_q[7:0]};
        endcase
    end

    assign beat_valid_o = valid_q;
    assign beat_o       = beat_q;
    assign mask_bit_o   = sh_q[0];

endmodule

`default_nettype wire

// ==== logic/elem_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// element unit types
// operations, widths and the structs passed between the stages
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "elem_defs.svh"

package elem_pkg;

    typedef logic [`ELEM_VREG_W-1:0]         vreg_t;
    typedef logic [`ELEM_XLEN-1:0]           xreg_t;
    typedef logic [7:0]                      vl_t;
    // position of an element or mask bit inside one register word
    typedef logic [$clog2(`ELEM_VREG_W)-1:0] elem_idx_t;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32
    } sew_t;

    typedef enum logic [3:0] {
        OP_XMV,
        OP_VPOPC,
        OP_VFIRST,
        OP_REDSUM,
        OP_REDAND,
        OP_REDOR,
        OP_REDXOR,
        OP_REDMINU,
        OP_REDMIN,
        OP_REDMAXU,
        OP_REDMAX
    } elem_op_t;

    typedef struct packed {
        elem_op_t op;
        sew_t     sew;
        vl_t      vl;
        xreg_t    init;
    } elem_cmd_t;

    // one per element or mask bit
    typedef struct packed {
        elem_op_t  op;
        sew_t      sew;
        elem_idx_t idx;
        logic      active;
        logic      first;
        logic      last;
    } elem_beat_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_DATA,
        SEQ_RUN
    } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/elem_reducer.sv ====
//////////////////////////////////////////////////////////////////////
// reducer
// folds beats into one scalar and registers the result for the core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "elem_defs.svh"

module elem_reducer (
    input  wire logic                 clk_i,
    input  wire logic                 async_rst_ni,
    input  wire logic                 beat_valid_i,
    input  wire elem_pkg::elem_beat_t beat_i,
    input  wire elem_pkg::xreg_t      elem_i,
    input  wire logic                 mask_bit_i,
    input  wire elem_pkg::xreg_t      init_i,
    output logic                      xreg_valid_o,
    output elem_pkg::xreg_t           xreg_o
);

    elem_pkg::xreg_t acc_q;
    elem_pkg::xreg_t acc_d;
    elem_pkg::xreg_t seed;
    elem_pkg::xreg_t seed_u;
    elem_pkg::xreg_t seed_s;
    elem_pkg::xreg_t elem_s;
    elem_pkg::xreg_t result_d;
    elem_pkg::xreg_t xreg_q;
    logic            found_q;
    logic            found_d;
    logic            valid_q;
    logic            mask_op;

    // narrow to the element width, zero or sign filled
    function automatic elem_pkg::xreg_t ext(input elem_pkg::xreg_t val,
                                            input elem_pkg::sew_t sew, input logic sgn);
        case (sew)
            elem_pkg::SEW_16: return {{(`ELEM_XLEN - 16){sgn & val[15]}}, val[15:0]};
            elem_pkg::SEW_32: return val;
            default:          return {{(`ELEM_XLEN - 8){sgn & val[7]}}, val[7:0]};
        endcase
    endfunction

    assign mask_op = (beat_i.op == elem_pkg::OP_VPOPC) || (beat_i.op == elem_pkg::OP_VFIRST);
    assign seed    = beat_i.first ? init_i : acc_q;
    assign seed_u  = ext(seed, beat_i.sew, 1'b0);
    assign seed_s  = ext(seed, beat_i.sew, 1'b1);
    assign elem_s  = ext(elem_i, beat_i.sew, 1'b1);

    always_comb begin
        acc_d   = seed;
        found_d = beat_i.first ? 1'b0 : found_q;
        case (beat_i.op)
            elem_pkg::OP_XMV: acc_d = elem_i;
            elem_pkg::OP_VPOPC: begin
                acc_d = (beat_i.first ? '0 : acc_q)
                      + elem_pkg::xreg_t'(beat_i.active & mask_bit_i);
            end
            elem_pkg::OP_VFIRST: begin
                // all ones until a set bit shows up
                acc_d = beat_i.first ? '1 : acc_q;
                if (beat_i.active & mask_bit_i & ~found_d) begin
                    acc_d   = elem_pkg::xreg_t'(beat_i.idx);
                    found_d = 1'b1;
                end
            end
            elem_pkg::OP_REDSUM: if (beat_i.active) acc_d = seed + elem_i;
            elem_pkg::OP_REDAND: if (beat_i.active) acc_d = seed & elem_i;
            elem_pkg::OP_REDOR:  if (beat_i.active) acc_d = seed | elem_i;
            elem_pkg::OP_REDXOR: if (beat_i.active) acc_d = seed ^ elem_i;
            elem_pkg::OP_REDMINU: begin
                if (beat_i.active && (elem_i < seed_u)) acc_d = elem_i;
            end
            elem_pkg::OP_REDMIN: begin
                if (beat_i.active && ($signed(elem_s) < $signed(seed_s))) acc_d = elem_s;
            end
            elem_pkg::OP_REDMAXU: begin
                if (beat_i.active && (elem_i > seed_u)) acc_d = elem_i;
            end
            elem_pkg::OP_REDMAX: begin
                if (beat_i.active && ($signed(elem_s) > $signed(seed_s))) acc_d = elem_s;
            end
            default: acc_d = seed;
        endcase
        // counts and indices are returned as they are
        result_d = mask_op ? acc_d : ext(acc_d, beat_i.sew, 1'b1);
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
            found_q <= 1'b0;
        end else begin
            valid_q <= beat_valid_i & beat_i.last;
            if (beat_valid_i) begin
                found_q <= found_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_valid_i) begin
            acc_q <= acc_d;
        end
        if (beat_valid_i & beat_i.last) begin
            xreg_q <= result_d;
        end
    end

    assign xreg_valid_o = valid_q;
    assign xreg_o       = xreg_q;

endmodule

`default_nettype wire

// ==== logic/elem_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// element sequencer
// takes commands and walks the elements of a word, one beat per cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "elem_defs.svh"

module elem_sequencer (
    input  wire logic                clk_i,
    input  wire logic                async_rst_ni,
    input  wire logic                op_rdy_i,
    input  wire elem_pkg::elem_cmd_t cmd_i,
    output logic                     op_ack_o,
    input  wire logic                fifo_empty_i,
    output logic                     pop_o,
    output logic                     beat_valid_o,
    output elem_pkg::elem_beat_t     beat_o,
    output elem_pkg::xreg_t          init_o
);

    elem_pkg::seq_state_t state_q;
    elem_pkg::seq_state_t state_d;
    elem_pkg::elem_idx_t  cnt_q;
    elem_pkg::elem_idx_t  cnt_d;
    elem_pkg::elem_idx_t  beats_m1;
    elem_pkg::elem_cmd_t  cmd_q;
    elem_pkg::xreg_t      init_q;
    logic                 beat_go;
    logic                 beat_last;

    // index of the last beat for the latched command
    always_comb begin
        case (cmd_q.op)
            elem_pkg::OP_XMV: beats_m1 = '0;
            elem_pkg::OP_VPOPC,
            elem_pkg::OP_VFIRST: beats_m1 = elem_pkg::elem_idx_t'(`ELEM_VREG_W - 1);
            default: begin
                case (cmd_q.sew)
                    elem_pkg::SEW_16: beats_m1 = elem_pkg::elem_idx_t'(`ELEM_VREG_W / 16 - 1);
                    elem_pkg::SEW_32: beats_m1 = elem_pkg::elem_idx_t'(`ELEM_VREG_W / 32 - 1);
                    default:          beats_m1 = elem_pkg::elem_idx_t'(`ELEM_VREG_W / 8 - 1);
                endcase
            end
        endcase
    end

    // the first beat leaves together with the pop of its word
    assign pop_o     = (state_q == elem_pkg::SEQ_WAIT_DATA) & ~fifo_empty_i;
    assign beat_go   = (state_q == elem_pkg::SEQ_RUN) | pop_o;
    assign beat_last = beat_go & (cnt_q == beats_m1);
    assign op_ack_o  = op_rdy_i & ((state_q == elem_pkg::SEQ_IDLE) | beat_last);

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        if (beat_go) begin
            cnt_d   = cnt_q + elem_pkg::elem_idx_t'(1);
            state_d = beat_last ? elem_pkg::SEQ_IDLE : elem_pkg::SEQ_RUN;
        end
        // a new command may follow straight after the last beat
        if (op_ack_o) begin
            cnt_d   = '0;
            state_d = elem_pkg::SEQ_WAIT_DATA;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= elem_pkg::SEQ_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            cmd_q <= cmd_i;
        end
        // staged one cycle so it meets the first beat at the shifter output
        if (beat_go & (cnt_q == '0)) begin
            init_q <= cmd_q.init;
        end
    end

    assign beat_valid_o  = beat_go;
    assign beat_o.op     = cmd_q.op;
    assign beat_o.sew    = cmd_q.sew;
    assign beat_o.idx    = cnt_q;
    assign beat_o.active = elem_pkg::vl_t'(cnt_q) < cmd_q.vl;
    assign beat_o.first  = (cnt_q == '0);
    assign beat_o.last   = (cnt_q == beats_m1);
    assign init_o        = init_q;

endmodule

`default_nettype wire

// ==== logic/elem_unit.sv ====
//////////////////////////////////////////////////////////////////////
// element unit top level
// reduces one register word per command to a scalar for the core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module elem_unit (
    input  wire logic                clk_i,
    input  wire logic                async_rst_ni,
    // command side
    input  wire logic                op_rdy_i,
    input  wire elem_pkg::elem_cmd_t cmd_i,
    output logic                     op_ack_o,
    // operand stream, credit based
    input  wire logic                operand_valid_i,
    input  wire elem_pkg::vreg_t     operand_i,
    output logic                     operand_credit_o,
    // scalar result
    output logic                     xreg_valid_o,
    output elem_pkg::xreg_t          xreg_o
);

    logic                 fifo_empty;
    elem_pkg::vreg_t      fifo_head;
    logic                 fifo_pop;
    logic                 seq_beat_valid;
    elem_pkg::elem_beat_t seq_beat;
    // init is staged inside the sequencer to line up with the shifter output
    elem_pkg::xreg_t      seq_init;
    logic                 sh_beat_valid;
    elem_pkg::elem_beat_t sh_beat;
    elem_pkg::xreg_t      sh_elem;
    logic                 sh_mask_bit;

    elem_operand_fifo u_fifo (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .operand_valid_i  (operand_valid_i),
        .operand_i        (operand_i),
        .pop_i            (fifo_pop),
        .empty_o          (fifo_empty),
        .head_o           (fifo_head),
        .operand_credit_o (operand_credit_o)
    );

    elem_sequencer u_seq (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_rdy_i     (op_rdy_i),
        .cmd_i        (cmd_i),
        .op_ack_o     (op_ack_o),
        .fifo_empty_i (fifo_empty),
        .pop_o        (fifo_pop),
        .beat_valid_o (seq_beat_valid),
        .beat_o       (seq_beat),
        .init_o       (seq_init)
    );

    elem_operand_shift u_shift (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .word_i       (fifo_head),
        .beat_valid_i (seq_beat_valid),
        .beat_i       (seq_beat),
        .beat_valid_o (sh_beat_valid),
        .beat_o       (sh_beat),
        .elem_o       (sh_elem),
        .mask_bit_o   (sh_mask_bit)
    );

    elem_reducer u_reducer (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .beat_valid_i (sh_beat_valid),
        .beat_i       (sh_beat),
        .elem_i       (sh_elem),
        .mask_bit_i   (sh_mask_bit),
        .init_i       (seq_init),
        .xreg_valid_o (xreg_valid_o),
        .xreg_o       (xreg_o)
    );

endmodule

`default_nettype wire

// ==== tb/elem_properties.sv ====
//////////////////////////////////////////////////////////////////////
// element unit assertions
// credit protocol and reset behavior, bound into the top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "elem_defs.svh"

module elem_properties (
    input  wire logic clk_i,
    input  wire logic async_rst_ni,
    input  wire logic op_ack_i,
    input  wire logic operand_valid_i,
    input  wire logic operand_credit_i,
    input  wire logic xreg_valid_i
);

    // words sent whose credit has not come back yet
    logic [2:0] in_flight_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            in_flight_q <= '0;
        end else begin
            in_flight_q <= in_flight_q + 3'(operand_valid_i) - 3'(operand_credit_i);
        end
    end

    a_send_needs_credit: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        operand_valid_i |-> (in_flight_q < 3'(`ELEM_OPERAND_CREDITS))
    ) else $error("operand sent while the source held no credit");

    a_quiet_in_reset: assert property (
        @(posedge clk_i) !async_rst_ni |-> (!op_ack_i && !xreg_valid_i)
    ) else $error("op_ack_o or xreg_valid_o high during reset");

    // a credit for a word never sent would lift the source above its limit
    a_credits_bounded: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        operand_credit_i |-> (in_flight_q != '0)
    ) else $error("outstanding credits exceed the buffer depth");

endmodule

bind elem_unit elem_properties u_props (
    .clk_i            (clk_i),
    .async_rst_ni     (async_rst_ni),
    .op_ack_i         (op_ack_o),
    .operand_valid_i  (operand_valid_i),
    .operand_credit_i (operand_credit_o),
    .xreg_valid_i     (xreg_valid_o)
);

`default_nettype wire

// ==== tb/elem_tb.sv ====
//////////////////////////////////////////////////////////////////////
// element unit testbench
// random commands and credit-limited operand words checked by a model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "elem_defs.svh"

module elem_tb;

    localparam int NUM_CMDS   = 300;
    localparam int WAIT_LIMIT = 2000;

    logic                clk_i;
    logic                async_rst_ni;
    logic                op_rdy_i;
    elem_pkg::elem_cmd_t cmd_i;
    logic                op_ack_o;
    logic                operand_valid_i;
    elem_pkg::vreg_t     operand_i;
    logic                operand_credit_o;
    logic                xreg_valid_o;
    elem_pkg::xreg_t     xreg_o;

    integer              seed;
    int                  error_count;
    int                  credits_held;
    int                  credit_pulses;
    int                  words_sent;
    int                  results_seen;
    elem_pkg::elem_cmd_t cmds [NUM_CMDS];
    elem_pkg::vreg_t     words [NUM_CMDS];
    // model queues hold one entry per taken command and per word sent
    elem_pkg::elem_cmd_t taken_q [$];
    elem_pkg::vreg_t     sent_q [$];

    elem_unit dut (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .op_rdy_i         (op_rdy_i),
        .cmd_i            (cmd_i),
        .op_ack_o         (op_ack_o),
        .operand_valid_i  (operand_valid_i),
        .operand_i        (operand_i),
        .operand_credit_o (operand_credit_o),
        .xreg_valid_o     (xreg_valid_o),
        .xreg_o           (xreg_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int unsigned width_of(input elem_pkg::sew_t sew);
        case (sew)
            elem_pkg::SEW_16: return 16;
            elem_pkg::SEW_32: return 32;
            default:          return 8;
        endcase
    endfunction

    function automatic logic [31:0] low_mask(input int unsigned w);
        if (w >= 32) begin
            return '1;
        end
        return (32'd1 << w) - 32'd1;
    endfunction

    function automatic logic [31:0] sign_extend(input logic [31:0] val, input int unsigned w);
        logic [31:0] m;
        logic [31:0] v;
        m = low_mask(w);
        v = val & m;
        if (v[w-1]) begin
            v = v | ~m;
        end
        return v;
    endfunction

    function automatic elem_pkg::xreg_t model_result(input elem_pkg::elem_cmd_t cmd,
                                                     input elem_pkg::vreg_t word);
        int unsigned w;
        int unsigned n;
        int          i;
        logic [31:0] m;
        logic [31:0] acc;
        logic [31:0] e;
        logic        found;
        w     = width_of(cmd.sew);
        n     = `ELEM_VREG_W / w;
        m     = low_mask(w);
        found = 1'b0;
        acc   = '0;
        case (cmd.op)
            elem_pkg::OP_XMV: acc = sign_extend(word[31:0], w);
            elem_pkg::OP_VPOPC: begin
                for (i = 0; i < `ELEM_VREG_W; i++) begin
                    if (i < int'(cmd.vl) && word[i]) begin
                        acc = acc + 32'd1;
                    end
                end
            end
            elem_pkg::OP_VFIRST: begin
                acc = '1;
                for (i = 0; i < `ELEM_VREG_W; i++) begin
                    if (!found && i < int'(cmd.vl) && word[i]) begin
                        acc   = 32'(i);
                        found = 1'b1;
                    end
                end
            end
            default: begin
                // combine init and active elements at the element width
                acc = cmd.init & m;
                for (i = 0; i < int'(n); i++) begin
                    if (i < int'(cmd.vl)) begin
                        e = 32'(word >> (i * w)) & m;
                        case (cmd.op)
                            elem_pkg::OP_REDSUM:  acc = (acc + e) & m;
                            elem_pkg::OP_REDAND:  acc = acc & e;
                            elem_pkg::OP_REDOR:   acc = acc | e;
                            elem_pkg::OP_REDXOR:  acc = acc ^ e;
                            elem_pkg::OP_REDMINU: if (e < acc) acc = e;
                            elem_pkg::OP_REDMAXU: if (e > acc) acc = e;
                            elem_pkg::OP_REDMIN: begin
                                if ($signed(sign_extend(e, w)) < $signed(sign_extend(acc, w)))
                                    acc = e;
                            end
                            elem_pkg::OP_REDMAX: begin
                                if ($signed(sign_extend(e, w)) > $signed(sign_extend(acc, w)))
                                    acc = e;
                            end
                            default: acc = acc;
                        endcase
                    end
                end
                acc = sign_extend(acc, w);
            end
        endcase
        return acc;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic elem_pkg::elem_cmd_t make_command();
        elem_pkg::elem_cmd_t cmd;
        logic [31:0]         r;
        r       = $unsigned($random(seed)) % 11;
        cmd.op  = elem_pkg::elem_op_t'(r[3:0]);
        r       = $unsigned($random(seed)) % 3;
        cmd.sew = elem_pkg::sew_t'(r[1:0]);
        r       = $unsigned($random(seed)) % 8;
        case (r)
            0:       cmd.vl = 8'd0;
            1:       cmd.vl = 8'd128;
            // short lengths land inside the element count of a word
            2, 3: begin
                r      = $unsigned($random(seed)) % 17;
                cmd.vl = r[7:0];
            end
            default: begin
                r      = $unsigned($random(seed)) % 129;
                cmd.vl = r[7:0];
            end
        endcase
        r = $unsigned($random(seed)) % 4;
        if (r == 0) begin
            r        = $unsigned($random(seed)) % 16;
            cmd.init = r;
        end else begin
            cmd.init = $random(seed);
        end
        return cmd;
    endfunction

    function automatic elem_pkg::vreg_t make_word();
        elem_pkg::vreg_t word;
        logic [31:0]     r;
        int              i;
        for (i = 0; i < `ELEM_VREG_W / 32; i++) begin
            word[i*32 +: 32] = $random(seed);
        end
        r = $unsigned($random(seed)) % 8;
        if (r == 0) begin
            word = '0;
        end else if (r == 1) begin
            // sparse mask so the first set bit sits further up
            word = word & (word >> 37) & (word << 11);
        end
        return word;
    endfunction

    task automatic end_with_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at time %0t: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at time %0t: %s got %h expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic issue_command(input elem_pkg::elem_cmd_t cmd);
        int   cycles;
        logic taken;
        cycles   = 0;
        taken    = 1'b0;
        op_rdy_i = 1'b1;
        cmd_i    = cmd;
        while (!taken) begin
            @(negedge clk_i);
            taken = op_ack_o;
            @(posedge clk_i);
            #2;
            cycles++;
            if (!taken && cycles > WAIT_LIMIT) begin
                report_error("command was never acknowledged");
            end
        end
        taken_q.push_back(cmd);
        op_rdy_i = 1'b0;
    endtask

    task automatic send_commands();
        int          k;
        logic [31:0] r;
        for (k = 0; k < NUM_CMDS; k++) begin
            // half the commands follow the previous one back to back
            r = $unsigned($random(seed)) % 2;
            if (r == 1) begin
                r = $unsigned($random(seed)) % 4;
                repeat (r) begin
                    @(posedge clk_i);
                    #2;
                end
            end
            issue_command(cmds[k]);
        end
    endtask

    task automatic send_operands();
        int          k;
        int          cycles;
        logic [31:0] r;
        for (k = 0; k < NUM_CMDS; k++) begin
            r = $unsigned($random(seed)) % 4;
            if (r == 0) begin
                r = $unsigned($random(seed)) % 6;
                repeat (r) begin
                    @(posedge clk_i);
                    #2;
                end
            end
            cycles = 0;
            while (credits_held == 0) begin
                @(posedge clk_i);
                #2;
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    report_error("no operand credit came back");
                end
            end
            operand_valid_i = 1'b1;
            operand_i       = words[k];
            credits_held--;
            words_sent++;
            sent_q.push_back(words[k]);
            @(posedge clk_i);
            #2;
            operand_valid_i = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // response side sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    initial begin : result_monitor
        elem_pkg::elem_cmd_t cmd;
        elem_pkg::vreg_t     word;
        forever begin
            @(negedge clk_i);
            if (async_rst_ni) begin
                if (operand_credit_o) begin
                    credits_held++;
                    credit_pulses++;
                    if (credits_held > `ELEM_OPERAND_CREDITS) begin
                        report_error("more credits returned than words sent");
                    end
                end
                if (xreg_valid_o) begin
                    if (taken_q.size() == 0) begin
                        report_error("result pulse without a taken command");
                    end
                    if (sent_q.size() == 0) begin
                        report_error("result produced before its operand word was sent");
                    end
                    cmd  = taken_q.pop_front();
                    word = sent_q.pop_front();
                    check_equal("xreg_o", xreg_o, model_result(cmd, word));
                    results_seen++;
                end
            end
        end
    end

    initial begin : main_flow
        int k;
        int cycles;
        seed            = 1;
        error_count     = 0;
        credits_held    = `ELEM_OPERAND_CREDITS;
        credit_pulses   = 0;
        words_sent      = 0;
        results_seen    = 0;
        async_rst_ni    = 1'b0;
        op_rdy_i        = 1'b0;
        cmd_i           = '0;
        operand_valid_i = 1'b0;
        operand_i       = '0;
        for (k = 0; k < NUM_CMDS; k++) begin
            cmds[k]  = make_command();
            words[k] = make_word();
        end
        repeat (5) @(posedge clk_i);
        #2;
        async_rst_ni = 1'b1;

        fork
            send_commands();
            send_operands();
        join

        cycles = 0;
        while (results_seen < NUM_CMDS) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_error("timed out waiting for the last results");
            end
        end
        // quiet period so a stray pulse is still seen
        repeat (4) @(posedge clk_i);
        check_equal("credit pulses", credit_pulses, words_sent);

        if (error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

`default_nettype wire
